// File: run.sh
#!/bin/sh
# Build and run the command engine testbench with Verilator
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_top -f tb.f > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_top > sim.log 2>&1 || echo "Simulator exited abnormally: ** FAIL **" >> sim.log
cat sim.log
grep -F -q '** FAIL **' sim.log && { echo "Simulation failed"; exit 1; } || { echo "Simulation passed"; exit 0; }

// File: source/capi_pkg.sv
// Shared field widths and bundle types of the command-issue engine, imported by every block
package capi_pkg;

  // ------------------------------------------------------------
  // Field widths
  // ------------------------------------------------------------

  // Tag field, sized for up to 256 outstanding commands
  localparam int TAG_WIDTH = 8;

  // Credit count and host command room
  localparam int CREDIT_WIDTH = 8;

  // Signed credit adjustment carries one extra bit for the sign
  localparam int ADJUST_WIDTH = CREDIT_WIDTH + 1;

  // Request payload fields
  localparam int OPCODE_WIDTH = 8;
  localparam int ADDRESS_WIDTH = 64;

  // ------------------------------------------------------------
  // Bundles
  // ------------------------------------------------------------

  // One accelerator request as posted into the queue
  typedef struct packed {
    logic [OPCODE_WIDTH-1:0]  opcode;
    logic [ADDRESS_WIDTH-1:0] address;
  } request_t;

  // One tagged command towards the host
  // Valid is a single-cycle strobe
  typedef struct packed {
    logic                     valid;
    logic [TAG_WIDTH-1:0]     tag;
    logic [OPCODE_WIDTH-1:0]  opcode;
    logic [ADDRESS_WIDTH-1:0] address;
  } command_t;

  // One host response
  // Credits is two's complement, sign in the top bit
  typedef struct packed {
    logic                    valid;
    logic [TAG_WIDTH-1:0]    tag;
    logic [ADJUST_WIDTH-1:0] credits;
  } response_t;

  // Everything the credit counter needs in one word
  typedef struct packed {
    logic                    issue;
    logic                    response_valid;
    logic [ADJUST_WIDTH-1:0] response_credits;
    logic [CREDIT_WIDTH-1:0] room;
  } credit_update_t;

endpackage

// File: source/command_control.sv
// Issue control inside the engine top that pops the queue head, claims a tag and a credit
module command_control (
  input  logic                              clock,
  input  logic                              rstn,
  input  capi_pkg::request_t                head,
  input  logic                              empty,
  input  logic [capi_pkg::TAG_WIDTH-1:0]    free_tag,
  input  logic                              any_free,
  input  logic [capi_pkg::CREDIT_WIDTH-1:0] credits,
  input  logic                              ready,
  output logic                              pop,
  output logic                              issue,
  output capi_pkg::command_t                command
);

  import capi_pkg::*;

  // Registered command with the strobe under reset and the payload without
  logic                 command_valid;
  logic [TAG_WIDTH-1:0] command_tag;
  request_t             command_request;

  // Combined go condition
  logic issue_ok;

  // ------------------------------------------------------------
  // Issue decision
  // ------------------------------------------------------------

  // All four resources must line up in the same cycle
  assign issue_ok = ready & (credits != '0) & ~empty & any_free;

  // Pop and issue pulse together at most once per cycle
  assign pop   = issue_ok;
  assign issue = issue_ok;

  // ------------------------------------------------------------
  // Command register
  // ------------------------------------------------------------

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      command_valid <= 1'b0;
    end else begin
      command_valid <= issue_ok;
    end
  end

  // Payload only loads on an issue
  always_ff @(posedge clock) begin
    if (issue_ok) begin
      command_tag     <= free_tag;
      command_request <= head;
    end
  end

  assign command.valid   = command_valid;
  assign command.tag     = command_tag;
  assign command.opcode  = command_request.opcode;
  assign command.address = command_request.address;

  // Strobe trails the issue by one clock and carries the tag claimed then
  assert property (@(posedge clock) disable iff (!rstn)
    issue |=> (command.valid && command.tag == $past(free_tag)))
    else $error("command_control: command strobe did not follow issue");

endmodule

// File: source/command_engine.sv
// Engine top: connects queue, tag pool, credit counter and issue control, sets the parameters
module command_engine #(
  parameter int QUEUE_DEPTH    = 4,
  parameter int TAG_COUNT      = 8,
  parameter int CREDIT_RESERVE = 4
) (
  input  logic                              clock,
  input  logic                              rstn,
  input  logic                              enabled,
  input  logic [capi_pkg::CREDIT_WIDTH-1:0] room,
  input  logic                              request_valid,
  input  capi_pkg::request_t                request,
  input  capi_pkg::response_t               response,
  output capi_pkg::command_t                command,
  output logic                              request_full,
  output logic [capi_pkg::CREDIT_WIDTH-1:0] credits
);

  import capi_pkg::*;

  // Queue to control
  request_t queue_head;
  logic     queue_empty;
  logic     pop;

  // Tag pool to control
  logic [TAG_WIDTH-1:0] free_tag;
  logic                 any_free;

  // Control to credit counter and tag pool
  logic           issue;
  logic           ready;
  credit_update_t credit_update;

  // Response credit field split out for the counter
  assign credit_update.issue            = issue;
  assign credit_update.response_valid   = response.valid;
  assign credit_update.response_credits = response.credits;
  assign credit_update.room             = room;

  command_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
    .clock     (clock),
    .rstn      (rstn),
    .push      (request_valid),
    .push_data (request),
    .pop       (pop),
    .head      (queue_head),
    .empty     (queue_empty),
    .full      (request_full)
  );

  tag_pool #(.TAG_COUNT(TAG_COUNT)) u_tags (
    .clock         (clock),
    .rstn          (rstn),
    .allocate      (issue),
    .release_valid (response.valid),
    .release_tag   (response.tag),
    .free_tag      (free_tag),
    .any_free      (any_free)
  );

  credit_control #(.CREDIT_RESERVE(CREDIT_RESERVE)) u_credits (
    .clock     (clock),
    .rstn      (rstn),
    .enabled   (enabled),
    .credit_in (credit_update),
    .credits   (credits),
    .ready     (ready)
  );

  command_control u_control (
    .clock    (clock),
    .rstn     (rstn),
    .head     (queue_head),
    .empty    (queue_empty),
    .free_tag (free_tag),
    .any_free (any_free),
    .credits  (credits),
    .ready    (ready),
    .pop      (pop),
    .issue    (issue),
    .command  (command)
  );

endmodule

// File: source/command_queue.sv
// Fall-through request queue; the head is visible as soon as a word is stored
module command_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                clock,
  input  logic                rstn,
  input  logic                push,
  input  capi_pkg::request_t  push_data,
  input  logic                pop,
  output capi_pkg::request_t  head,
  output logic                empty,
  output logic                full
);

  import capi_pkg::*;

  // Depth is a power of two, so the pointers wrap on their own
  localparam int PTR_WIDTH = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(QUEUE_DEPTH + 1);

  // Storage, no reset on payload
  request_t storage [QUEUE_DEPTH];

  logic [PTR_WIDTH-1:0]   write_ptr;
  logic [PTR_WIDTH-1:0]   read_ptr;
  logic [COUNT_WIDTH-1:0] count;

  // Qualified strobes
  logic do_push;
  logic do_pop;

  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  // ------------------------------------------------------------
  // Storage write
  // ------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (do_push) begin
      storage[write_ptr] <= push_data;
    end
  end

  // ------------------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------------------

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      write_ptr <= '0;
      read_ptr  <= '0;
      count     <= '0;
    end else begin
      if (do_push) begin
        write_ptr <= write_ptr + PTR_WIDTH'(1);
      end
      if (do_pop) begin
        read_ptr <= read_ptr + PTR_WIDTH'(1);
      end
      // Simultaneous push and pop keeps the count
      case ({do_push, do_pop})
        2'b10:   count <= count + COUNT_WIDTH'(1);
        2'b01:   count <= count - COUNT_WIDTH'(1);
        default: count <= count;
      endcase
    end
  end

  // Head comes straight out of storage
  assign head  = storage[read_ptr];
  assign empty = (count == '0);
  assign full  = (count == COUNT_WIDTH'(QUEUE_DEPTH));

  // Writer must honour the full level
  assert property (@(posedge clock) disable iff (!rstn) push |-> !full)
    else $error("command_queue: push while full");

  // Control must not pop an empty queue
  assert property (@(posedge clock) disable iff (!rstn) pop |-> !empty)
    else $error("command_queue: pop while empty");

endmodule

// File: source/credit_control.sv
// Credit counter: loads host room less a reserve on enable, then follows issues and responses
module credit_control #(
  parameter int CREDIT_RESERVE = 4
) (
  input  logic                              clock,
  input  logic                              rstn,
  input  logic                              enabled,
  input  capi_pkg::credit_update_t          credit_in,
  output logic [capi_pkg::CREDIT_WIDTH-1:0] credits,
  output logic                              ready
);

  import capi_pkg::*;

  // Registered copy of the enable level
  logic enabled_q;
  // Set once the count has been loaded from room
  logic initialized;
  // Net change for this cycle, one bit wider than the adjustment
  logic signed [ADJUST_WIDTH:0] delta;
  // Count loaded on the first enabled cycle
  logic [CREDIT_WIDTH-1:0] start_count;

  // ------------------------------------------------------------
  // Enable register
  // ------------------------------------------------------------

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enabled_q <= 1'b0;
    end else begin
      enabled_q <= enabled;
    end
  end

  // Host room less the reserve held back
  assign start_count = credit_in.room - CREDIT_WIDTH'(CREDIT_RESERVE);

  // Response adjustment, sign extended, minus one per issue
  // A negative adjustment withdraws credits
  always_comb begin
    delta = '0;
    if (credit_in.response_valid) begin
      delta = {credit_in.response_credits[ADJUST_WIDTH-1], credit_in.response_credits};
    end
    if (credit_in.issue) begin
      delta = delta - {{ADJUST_WIDTH{1'b0}}, 1'b1};
    end
  end

  // ------------------------------------------------------------
  // Credit count
  // ------------------------------------------------------------

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      credits     <= '0;
      initialized <= 1'b0;
    end else if (enabled_q) begin
      if (!initialized) begin
        // First enabled cycle, sample room
        credits     <= start_count;
        initialized <= 1'b1;
      end else begin
        // Modulo add, issue and response may land together
        credits <= credits + delta[CREDIT_WIDTH-1:0];
      end
    end
  end

  // Issue is allowed only once loaded and while still enabled
  assign ready = initialized & enabled_q;

  // The control block must never spend a credit it does not have
  assert property (@(posedge clock) disable iff (!rstn)
    credit_in.issue |-> (ready && credits != '0))
    else $error("credit_control: issue with no credit or not ready");

endmodule

// File: source/tag_pool.sv
// Tag allocator: bitmap of tags in use, hands out the lowest free one, frees on response
module tag_pool #(
  parameter int TAG_COUNT = 8
) (
  input  logic                           clock,
  input  logic                           rstn,
  input  logic                           allocate,
  input  logic                           release_valid,
  input  logic [capi_pkg::TAG_WIDTH-1:0] release_tag,
  output logic [capi_pkg::TAG_WIDTH-1:0] free_tag,
  output logic                           any_free
);

  import capi_pkg::*;

  localparam int INDEX_WIDTH = (TAG_COUNT > 1) ? $clog2(TAG_COUNT) : 1;

  // One bit per tag, set while a command is outstanding
  logic [TAG_COUNT-1:0]   in_use;
  logic [TAG_COUNT-1:0]   in_use_next;
  logic [INDEX_WIDTH-1:0] free_index;
  logic [INDEX_WIDTH-1:0] release_index;
  logic                   release_in_range;

  // ------------------------------------------------------------
  // Lowest free tag
  // ------------------------------------------------------------

  // Scan downwards so the last hit is the lowest index
  always_comb begin
    free_index = '0;
    for (int i = TAG_COUNT - 1; i >= 0; i--) begin
      if (!in_use[i]) begin
        free_index = INDEX_WIDTH'(i);
      end
    end
  end

  assign any_free = ~&in_use;
  assign free_tag = TAG_WIDTH'(free_index);

  // Release index, ignored when out of range
  assign release_index    = release_tag[INDEX_WIDTH-1:0];
  assign release_in_range = (int'(release_tag) < TAG_COUNT);

  // ------------------------------------------------------------
  // Bitmap update
  // ------------------------------------------------------------

  // Allocate and release can share a cycle
  // The two never name the same tag, one is free and one is busy
  always_comb begin
    in_use_next = in_use;
    if (release_valid && release_in_range) begin
      in_use_next[release_index] = 1'b0;
    end
    if (allocate && any_free) begin
      in_use_next[free_index] = 1'b1;
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      in_use <= '0;
    end else begin
      in_use <= in_use_next;
    end
  end

  // Host may only return a tag that was issued and is still outstanding
  assert property (@(posedge clock) disable iff (!rstn)
    release_valid |-> (release_in_range && in_use[release_index]))
    else $error("tag_pool: release of tag %0d not in use", release_tag);

endmodule

// File: tb.f
source/capi_pkg.sv
source/credit_control.sv
source/command_queue.sv
source/tag_pool.sv
source/command_control.sv
source/command_engine.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: verif/tb_checker.sv
// Testbench checker instantiated beside the DUT in tb_top to model credits, order and tags
module tb_checker #(
  parameter int QUEUE_DEPTH    = 4,
  parameter int TAG_COUNT      = 8,
  parameter int CREDIT_RESERVE = 4
) (
  input  logic                              clock,
  input  logic                              rstn,
  input  logic                              enabled,
  input  logic [capi_pkg::CREDIT_WIDTH-1:0] room,
  input  logic                              request_valid,
  input  capi_pkg::request_t                request,
  input  capi_pkg::response_t               response,
  input  capi_pkg::command_t                command,
  input  logic                              request_full,
  input  logic [capi_pkg::CREDIT_WIDTH-1:0] credits,
  output int                                error_count,
  output int                                command_count,
  output logic                              timed_out
);
  timeunit 1ns;
  timeprecision 100ps;

  import capi_pkg::*;

  // Four times the longest sequence
  localparam int CYCLE_LIMIT = 4000;

  int check_errors = 0;
  int count_errors = 0;
  int cycle_count = 0;

  // Expected state after the previous edge
  logic       model_enabled;
  logic       model_loaded;
  logic [7:0] model_credits;
  int         model_fill;
  request_t   pending[$];
  bit [255:0] outstanding;
  request_t   head_request;

  // Inputs seen at the previous edge
  logic       last_rstn = 1'b1;
  logic       last_enabled;
  logic [7:0] last_room;
  logic       last_push;
  request_t   last_request;
  response_t  last_response;

  assign error_count = check_errors + count_errors;

  // Next count from the previous one plus the response and less the issue
  function automatic logic [7:0] next_credits(input logic [7:0] previous, input logic issued,
                                              input response_t resp);
    int value;
    value = int'(previous);
    if (resp.valid) value = value + int'($signed(resp.credits));
    if (issued) value = value - 1;
    return value[7:0];
  endfunction

  function void flag_mismatch(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
    $display("Error at %0d ns: %s expected 0x%0h, actual 0x%0h", $time, name, expected, actual);
    check_errors++;
  endfunction

  function void flag_problem(input string text);
    $display("Error at %0d ns: %s", $time, text);
    check_errors++;
  endfunction

  // Commands seen since the last reset
  task automatic check_issued(input string what, input int expected);
    if (command_count != expected) begin
      $display("Error at %0d ns: %s command count expected %0d, actual %0d",
               $time, what, expected, command_count);
      count_errors++;
    end
  endtask

  // ------------------------------------------------------------
  // Per-edge comparison
  // ------------------------------------------------------------

  always @(posedge clock) begin
    cycle_count++;
    timed_out = (cycle_count >= CYCLE_LIMIT);
    if (cycle_count == CYCLE_LIMIT) begin
      $display("Timeout: the run was still busy after %0d cycles", CYCLE_LIMIT);
    end
    if (!rstn || !last_rstn) begin
      // Outputs low once a reset edge has gone by
      if (!last_rstn && (command.valid || request_full || credits != '0)) begin
        flag_problem("outputs not cleared by reset");
      end
      model_enabled = 1'b0;
      model_loaded = 1'b0;
      model_credits = '0;
      model_fill = 0;
      pending.delete();
      outstanding = '0;
      command_count = 0;
    end else begin
      // A strobe now is an issue at the previous edge
      if (command.valid && !(model_enabled && model_loaded && model_credits != '0)) begin
        flag_problem("command issued without ready or credit");
      end
      if (model_enabled) begin
        if (!model_loaded) begin
          model_credits = last_room - 8'(CREDIT_RESERVE);
          model_loaded = 1'b1;
        end else begin
          model_credits = next_credits(model_credits, command.valid, last_response);
        end
      end
      model_enabled = last_enabled;
      if (credits !== model_credits) begin
        flag_mismatch("credits", 64'(model_credits), 64'(credits));
      end
      if (command.valid) begin
        command_count++;
        if (pending.size() == 0) begin
          flag_problem("command issued with no pending request");
        end else begin
          head_request = pending.pop_front();
          if (command.opcode !== head_request.opcode) begin
            flag_mismatch("command.opcode", 64'(head_request.opcode), 64'(command.opcode));
          end
          if (command.address !== head_request.address) begin
            flag_mismatch("command.address", head_request.address, command.address);
          end
        end
        if (int'(command.tag) >= TAG_COUNT || outstanding[command.tag]) begin
          flag_problem($sformatf("tag %0d out of range or already outstanding", command.tag));
        end
        outstanding[command.tag] = 1'b1;
      end
      if (last_response.valid) outstanding[last_response.tag] = 1'b0;
      // Pop before push since a word pushed at an edge cannot leave at that edge
      if (last_push) pending.push_back(last_request);
      model_fill = model_fill + int'(last_push) - int'(command.valid);
      if (request_full !== (model_fill == QUEUE_DEPTH)) begin
        flag_mismatch("request_full", 64'(model_fill == QUEUE_DEPTH), 64'(request_full));
      end
    end
    last_rstn = rstn;
    last_enabled = enabled;
    last_room = room;
    last_push = request_valid && !request_full;
    last_request = request;
    last_response = response;
  end

endmodule

// File: verif/tb_top.sv
// Testbench top for the command engine: clock, reset, request sequences and a host response model
module tb_top;
  timeunit 1ns;
  timeprecision 100ps;

  import capi_pkg::*;

  localparam int QUEUE_DEPTH    = 4;
  localparam int TAG_COUNT      = 8;
  localparam int CREDIT_RESERVE = 4;

  logic                    clock = 1'b0;
  logic                    rstn;
  logic                    enabled;
  logic [CREDIT_WIDTH-1:0] room;
  logic                    request_valid;
  request_t                request;
  response_t               response;
  command_t                command;
  logic                    request_full;
  logic [CREDIT_WIDTH-1:0] credits;
  int                      error_count;
  int                      command_count;
  logic                    timed_out;

  // Host side state, tags wait here in issue order
  logic                 hold_responses;
  logic [TAG_WIDTH-1:0] host_tags[$];

  always #5 clock = ~clock;

  command_engine #(.QUEUE_DEPTH(QUEUE_DEPTH), .TAG_COUNT(TAG_COUNT),
                   .CREDIT_RESERVE(CREDIT_RESERVE)) uut (.*);

  tb_checker #(.QUEUE_DEPTH(QUEUE_DEPTH), .TAG_COUNT(TAG_COUNT),
               .CREDIT_RESERVE(CREDIT_RESERVE)) u_checker (.*);

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------

  // Next edge plus the drive offset
  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  // Two cycles of reset, room set for the next enable
  task automatic apply_reset(input logic [CREDIT_WIDTH-1:0] new_room);
    next_cycle();
    rstn = 1'b0;
    enabled = 1'b0;
    hold_responses = 1'b1;
    room = new_room;
    repeat (2) next_cycle();
    rstn = 1'b1;
  endtask

  // Random request, held back while the queue is full
  task automatic send_request();
    while (request_full) begin
      next_cycle();
    end
    request_valid = 1'b1;
    request.opcode = 8'($urandom);
    request.address = {$urandom, $urandom};
    next_cycle();
    request_valid = 1'b0;
  endtask

  task automatic wait_commands(input int count);
    while (command_count < count) begin
      next_cycle();
    end
  endtask

  // Checked away from the host's drive time
  task automatic drain_host();
    #2;
    while (host_tags.size() != 0 || response.valid) begin
      @(posedge clock);
      #3;
    end
    next_cycle();
  endtask

  // Mostly plus one, sometimes two, zero or a withdrawal
  // Low counts always get two back so the run cannot stall
  function automatic logic [ADJUST_WIDTH-1:0] pick_adjustment(input logic [7:0] current);
    int pick;
    pick = int'($urandom_range(9, 0));
    if (current < 8'd3) return 9'd2;
    if (pick == 0) return 9'h1ff;
    if (pick == 1) return 9'd0;
    if (pick <= 4) return 9'd2;
    return 9'd1;
  endfunction

  // ------------------------------------------------------------
  // Host model
  // ------------------------------------------------------------

  initial begin
    int   wait_cycles;
    logic in_reset;
    logic held;
    response = '0;
    wait_cycles = 0;
    forever begin
      @(posedge clock);
      in_reset = !rstn;
      held = hold_responses;
      if (in_reset) host_tags.delete();
      else if (command.valid) host_tags.push_back(command.tag);
      #1;
      response = '0;
      if (!in_reset && !held && host_tags.size() != 0) begin
        if (wait_cycles > 0) begin
          wait_cycles--;
        end else begin
          response.valid = 1'b1;
          response.tag = host_tags.pop_front();
          response.credits = pick_adjustment(credits);
          wait_cycles = int'($urandom_range(2, 0));
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------

  initial begin
    void'($urandom(32'h9101));
    rstn = 1'b0;
    enabled = 1'b0;
    room = '0;
    request_valid = 1'b0;
    request = '0;
    hold_responses = 1'b1;

    // Credit stall, queue filled before enable
    apply_reset(8'd9);
    repeat (4) send_request();
    repeat (5) next_cycle();
    enabled = 1'b1;
    repeat (3) send_request();
    wait_commands(5);
    repeat (10) next_cycle();
    u_checker.check_issued("credit stall", 5);
    hold_responses = 1'b0;
    wait_commands(7);
    drain_host();

    // Tag stall, credits to spare
    apply_reset(8'd20);
    enabled = 1'b1;
    repeat (10) send_request();
    wait_commands(8);
    repeat (10) next_cycle();
    u_checker.check_issued("tag stall", 8);
    hold_responses = 1'b0;
    wait_commands(10);
    drain_host();

    // Random traffic with live responses
    apply_reset(8'($urandom_range(40, 6)));
    enabled = 1'b1;
    hold_responses = 1'b0;
    for (int i = 0; i < 60; i++) begin
      send_request();
      repeat ($urandom_range(2, 0)) next_cycle();
    end
    wait_commands(60);
    drain_host();

    next_cycle();
    $display("Run complete with %0d errors", error_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Run limit reached
  initial begin
    wait (timed_out === 1'b1);
    $display("Run stopped with %0d errors", error_count);
    $display("** FAIL **");
    $finish;
  end

endmodule
